/* project.f */
source/zport_pkg.sv
source/zport_bus_sync.sv
source/zport_xt_cfg.sv
source/zport_pager.sv
source/zport_readback.sv
source/zports_top.sv
tests/zports_checker.sv
tests/zports_tb.sv

/* source/zport_bus_sync.sv */
////////////////////////////////////////
// samples Z80 I/O cycles on zclk and hands out
// single-cycle strobes with the decoded port selects
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zport_bus_sync
(
	input  wire                   zclk,
	input  wire                   rst_n,
	input  wire [15:0]            a,
	input  wire [7:0]             din,
	input  wire                   iorq_n,
	input  wire                   rd_n,
	input  wire                   wr_n,
	output zport_pkg::io_strobe_t io
);

	// async bus levels
	wire iowr = ~(iorq_n | wr_n);
	wire iord = ~(iorq_n | rd_n);

	logic iowr_q; // level seen at last edge
	logic iord_q;
	logic wr_stb;
	logic rd_stb;

	wire [7:0] loa = a[7:0];

	////////////////////////////////////////
	// edge detect, strobe drops after one cycle
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_q <= 1'b0;
			iord_q <= 1'b0;
			wr_stb <= 1'b0;
			rd_stb <= 1'b0;
		end
		else
		begin
			iowr_q <= iowr;
			iord_q <= iord;
			wr_stb <= iowr & ~iowr_q;
			rd_stb <= iord & ~iord_q;
		end
	end

	// selects shared by the register blocks
	assign io = '{
		wr:      wr_stb,
		rd:      rd_stb,
		lo_addr: loa,
		hi_addr: a[15:8],
		data:    din,
		sel_fe:  (loa == zport_pkg::PORT_FE),
		sel_fd:  (loa == zport_pkg::PORT_FD),
		sel_xt:  (loa == zport_pkg::PORT_XT),
		sel_f7:  (loa == zport_pkg::PORT_F7)
	};

endmodule

`default_nettype wire

/* source/zport_pager.sv */
////////////////////////////////////////
// 7FFD and EFF7 paging with the 1 MB lock,
// also owns the video page register
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zport_pager
(
	input  wire                        zclk,
	input  wire                        rst_n,
	input  wire zport_pkg::io_strobe_t io,
	input  wire                        dos,
	output zport_pkg::page_state_t     page,
	output logic [7:0]                 vpage
);

	logic [7:0] p7ffd;
	logic [7:0] peff7_int;
	logic       block7ffd; // 7FFD frozen until reset
	logic       rom_sel;
	logic [5:0] page1m;

	wire block1m = peff7_int[2];
	wire [7:0] d = io.data;

	wire p7ffd_wr = io.wr & io.sel_fd & ~io.hi_addr[7] & ~block7ffd;
	wire peff7_wr = io.wr & io.sel_f7 & io.hi_addr[0] & ~io.hi_addr[4] & ~dos; // EFF7, not in shadow
	wire vpage_wr = io.wr & io.sel_xt & (io.hi_addr == zport_pkg::XT_VPAGE);

	////////////////////////////////////////
	// 7FFD and video page
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd     <= 8'h00;
			block7ffd <= 1'b0;
			rom_sel   <= 1'b0;
			page1m    <= 6'd0;
			vpage     <= zport_pkg::RST_VPAGE;
		end
		else if (p7ffd_wr)
		begin
			p7ffd     <= d;
			block7ffd <= p7ffd[5] & block1m; // old bit 5
			rom_sel   <= d[4];
			page1m    <= {block1m ? 3'b000 : {d[5], d[7:6]}, d[2:0]};
			vpage     <= {6'b000001, d[3], 1'b1}; // screen 5 or 7
		end
		else if (vpage_wr)
			vpage <= d;
	end

	// EFF7
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			peff7_int <= 8'h00;
		else if (peff7_wr)
			peff7_int <= d; // bit 2 blocks 1 MB
	end

	assign page = '{
		p7ffd:         p7ffd,
		peff7:         block1m ? {peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]}
		                       : peff7_int,
		pent1m_page:   page1m,
		pent1m_rom:    rom_sel,
		pent1m_1m_on:  ~block1m,
		pent1m_ram0_0: peff7_int[3]
	};

endmodule

`default_nettype wire

/* source/zport_pkg.sv */
////////////////////////////////////////
// port addresses, register indices and bus
// bundles of the Z80 port block, used by scoped name
////////////////////////////////////////
`default_nettype none

package zport_pkg;

	////////////////////////////////////////
	// low address byte of each port
	localparam logic [7:0] PORT_FE = 8'hFE; // keys, tape, border
	localparam logic [7:0] PORT_F6 = 8'hF6;
	localparam logic [7:0] PORT_FD = 8'hFD; // 7FFD paging
	localparam logic [7:0] PORT_XT = 8'hAF; // extension registers
	localparam logic [7:0] PORT_F7 = 8'hF7; // EFF7
	localparam logic [7:0] PORT_DF = 8'hDF; // mouse
	localparam logic [7:0] PORT_BE = 8'hBE; // config readback

	////////////////////////////////////////
	// extension register index, high address byte of #nnAF
	localparam logic [7:0] XT_VCONF    = 8'h00;
	localparam logic [7:0] XT_VPAGE    = 8'h01;
	localparam logic [7:0] XT_XOFFSL   = 8'h02;
	localparam logic [7:0] XT_XOFFSH   = 8'h03;
	localparam logic [7:0] XT_YOFFSL   = 8'h04;
	localparam logic [7:0] XT_YOFFSH   = 8'h05;
	localparam logic [7:0] XT_TSCONF   = 8'h06;
	localparam logic [7:0] XT_PALSEL   = 8'h07;
	localparam logic [7:0] XT_BORDER   = 8'h0F;
	localparam logic [7:0] XT_RAMPAGE  = 8'h10; // #10..#13
	localparam logic [7:0] XT_SYSCONF  = 8'h20;
	localparam logic [7:0] XT_MEMCONF  = 8'h21;
	localparam logic [7:0] XT_HSINT    = 8'h22;
	localparam logic [7:0] XT_VSINTL   = 8'h23;
	localparam logic [7:0] XT_VSINTH   = 8'h24;
	localparam logic [7:0] XT_IM2VECT  = 8'h25;

	// a[11:8] of a #BE read
	localparam logic [3:0] BE_P7FFD = 4'hA;
	localparam logic [3:0] BE_PEFF7 = 4'hB;

	// values after reset
	localparam logic [7:0] RST_HINT     = 8'd2; // pentagon timing
	localparam logic [7:0] RST_IM2VECT  = 8'hFF;
	localparam logic [3:0] RST_PALSEL   = 4'hF;
	localparam logic [7:0] RST_VPAGE    = 8'h05;
	localparam logic [7:0] RST_RAMPAGE0 = 8'h00;
	localparam logic [7:0] RST_RAMPAGE1 = 8'h05;
	localparam logic [7:0] RST_RAMPAGE2 = 8'h02;
	localparam logic [7:0] RST_RAMPAGE3 = 8'h00;

	// decoded I/O cycle
	typedef struct packed {
		logic       wr;      // one zclk per bus write
		logic       rd;      // one zclk per bus read
		logic [7:0] lo_addr;
		logic [7:0] hi_addr;
		logic [7:0] data;
		logic       sel_fe;
		logic       sel_fd;
		logic       sel_xt;
		logic       sel_f7;
	} io_strobe_t;

	typedef struct packed {
		logic [7:0] vconf;
		logic [7:0] vpage;
		logic [8:0] x_offs;
		logic [8:0] y_offs;
		logic [7:0] tsconf;
		logic [3:0] palsel;
	} video_cfg_t;

	typedef struct packed {
		logic [7:0]      sysconf;
		logic [7:0]      memconf;
		logic [7:0]      hint_beg;
		logic [8:0]      vint_beg;
		logic [7:0]      im2vect;
		logic [3:0][7:0] rampage; // window 0 in the low byte
	} sys_cfg_t;

	typedef struct packed {
		logic [7:0] p7ffd;
		logic [7:0] peff7;        // masked under block1m
		logic [5:0] pent1m_page;
		logic       pent1m_rom;
		logic       pent1m_1m_on;
		logic       pent1m_ram0_0;
	} page_state_t;

endpackage

`default_nettype wire

/* source/zport_readback.sv */
////////////////////////////////////////
// read data to the Z80 plus the port hit flags,
// all combinational from the bus
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zport_readback
(
	input  wire [15:0]                  a,
	input  wire                         iorq_n,
	input  wire                         rd_n,
	input  wire                         dos,
	input  wire [4:0]                   keys_in,
	input  wire                         tape_read,
	input  wire [7:0]                   mus_in,
	input  wire zport_pkg::page_state_t page,
	output logic [7:0]                  dout,
	output wire                         porthit,
	output wire                         dataout
);

	wire [7:0] loa = a[7:0];
	logic [7:0] be_mux;

	// #BE config readback
	always_comb
	begin
		case (a[11:8])
			zport_pkg::BE_P7FFD: be_mux = page.p7ffd;
			zport_pkg::BE_PEFF7: be_mux = page.peff7;
			default:             be_mux = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (loa)
			zport_pkg::PORT_FE,
			zport_pkg::PORT_F6: dout = {1'b1, tape_read, 1'b0, keys_in};
			zport_pkg::PORT_DF: dout = mus_in;
			zport_pkg::PORT_BE: dout = be_mux;
			default:            dout = 8'hFF; // floating bus
		endcase
	end

	assign porthit = (loa == zport_pkg::PORT_FE) || (loa == zport_pkg::PORT_F6) ||
	                 (loa == zport_pkg::PORT_FD) || (loa == zport_pkg::PORT_XT) ||
	                 (loa == zport_pkg::PORT_DF) || (loa == zport_pkg::PORT_BE) ||
	                 ((loa == zport_pkg::PORT_F7) && !dos); // F7 off in shadow

	assign dataout = porthit & ~iorq_n & ~rd_n;

endmodule

`default_nettype wire

/* source/zport_xt_cfg.sv */
////////////////////////////////////////
// extension registers behind #nnAF and the border,
// loaded from the write strobe of the bus sampler
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zport_xt_cfg
(
	input  wire                        zclk,
	input  wire                        rst_n,
	input  wire zport_pkg::io_strobe_t io,
	input  wire [7:0]                  vpage,  // owned by the pager
	output zport_pkg::video_cfg_t      video,
	output zport_pkg::sys_cfg_t        sys,
	output logic [7:0]                 border
);

	logic [7:0]      vconf;
	logic [8:0]      x_offs;
	logic [8:0]      y_offs;
	logic [7:0]      tsconf;
	logic [3:0]      palsel;
	logic [7:0]      sysconf;
	logic [7:0]      memconf;
	logic [7:0]      hint_beg;
	logic [8:0]      vint_beg;
	logic [7:0]      im2vect;
	logic [3:0][7:0] rampage;

	wire [7:0] hoa = io.hi_addr;
	wire       xt_wr = io.wr & io.sel_xt;
	wire       rampage_hit = (hoa[7:2] == zport_pkg::XT_RAMPAGE[7:2]); // #10..#13

	////////////////////////////////////////
	// register file
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			vconf    <= 8'h00;
			x_offs   <= 9'd0;
			y_offs   <= 9'd0;
			tsconf   <= 8'h00;
			palsel   <= zport_pkg::RST_PALSEL;
			sysconf  <= 8'h00;
			memconf  <= 8'h00;
			hint_beg <= zport_pkg::RST_HINT;
			vint_beg <= 9'd0;
			im2vect  <= zport_pkg::RST_IM2VECT;
			rampage  <= {zport_pkg::RST_RAMPAGE3, zport_pkg::RST_RAMPAGE2,
			             zport_pkg::RST_RAMPAGE1, zport_pkg::RST_RAMPAGE0};
		end
		else if (xt_wr)
		begin
			case (hoa)
				zport_pkg::XT_VCONF:   vconf          <= io.data;
				zport_pkg::XT_XOFFSL:  x_offs[7:0]    <= io.data;
				zport_pkg::XT_XOFFSH:  x_offs[8]      <= io.data[0];
				zport_pkg::XT_YOFFSL:  y_offs[7:0]    <= io.data;
				zport_pkg::XT_YOFFSH:  y_offs[8]      <= io.data[0];
				zport_pkg::XT_TSCONF:  tsconf         <= io.data;
				zport_pkg::XT_PALSEL:  palsel         <= io.data[3:0];
				zport_pkg::XT_SYSCONF: sysconf        <= io.data;
				zport_pkg::XT_MEMCONF: memconf        <= io.data;
				zport_pkg::XT_HSINT:   hint_beg       <= io.data;
				zport_pkg::XT_VSINTL:  vint_beg[7:0]  <= io.data;
				zport_pkg::XT_VSINTH:  vint_beg[8]    <= io.data[0];
				zport_pkg::XT_IM2VECT: im2vect        <= io.data;
				default: ;
			endcase
			if (rampage_hit)
				rampage[hoa[1:0]] <= io.data; // window from a[9:8]
		end
	end

	// border, #FE gives only the colour bits
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			border <= 8'h00;
		else if (io.wr & io.sel_fe)
			border <= {5'b11110, io.data[2:0]};
		else if (xt_wr && hoa == zport_pkg::XT_BORDER)
			border <= io.data;
	end

	assign video = '{
		vconf:  vconf,
		vpage:  vpage,
		x_offs: x_offs,
		y_offs: y_offs,
		tsconf: tsconf,
		palsel: palsel
	};

	assign sys = '{
		sysconf:  sysconf,
		memconf:  memconf,
		hint_beg: hint_beg,
		vint_beg: vint_beg,
		im2vect:  im2vect,
		rampage:  rampage
	};

endmodule

`default_nettype wire

/* source/zports_top.sv */
////////////////////////////////////////
// Z80 port block top, bus sampler feeding the
// register blocks and the readback path
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zports_top
(
	input  wire                         zclk,
	input  wire                         rst_n,
	input  wire [15:0]                  a,
	input  wire [7:0]                   din,
	input  wire                         iorq_n,
	input  wire                         rd_n,
	input  wire                         wr_n,
	input  wire                         dos,
	input  wire [4:0]                   keys_in,
	input  wire                         tape_read,
	input  wire [7:0]                   mus_in,
	output wire zport_pkg::video_cfg_t  video,
	output wire zport_pkg::sys_cfg_t    sys,
	output wire [7:0]                   border,
	output wire zport_pkg::page_state_t page,
	output wire [7:0]                   dout,
	output wire                         porthit,
	output wire                         dataout
);

	wire zport_pkg::io_strobe_t io;
	wire [7:0]                  vpage;

	zport_bus_sync u_bus_sync (.zclk(zclk), .rst_n(rst_n), .a(a), .din(din),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .io(io));

	zport_xt_cfg u_xt_cfg (.zclk(zclk), .rst_n(rst_n), .io(io), .vpage(vpage),
		.video(video), .sys(sys), .border(border));

	zport_pager u_pager (.zclk(zclk), .rst_n(rst_n), .io(io), .dos(dos),
		.page(page), .vpage(vpage));

	zport_readback u_readback (.a(a), .iorq_n(iorq_n), .rd_n(rd_n), .dos(dos),
		.keys_in(keys_in), .tape_read(tape_read), .mus_in(mus_in), .page(page),
		.dout(dout), .porthit(porthit), .dataout(dataout));

endmodule

`default_nettype wire

/* tests/zports_checker.sv */
////////////////////////////////////////
// strobe and bus-drive assertions, bound into
// the bus sampler and the top level
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zports_checker
(
	input wire zclk,
	input wire rst_n,
	input wire wr,
	input wire rd,
	input wire porthit,
	input wire dataout
);

	int fail_count = 0; // assertion failures so far

	// one zclk per bus write
	wr_single: assert property (@(posedge zclk) disable iff (!rst_n) wr |=> !wr)
	else
	begin
		fail_count++;
		$error("write strobe high two cycles in a row");
	end

	wr_rd_apart: assert property (@(posedge zclk) disable iff (!rst_n) !(wr && rd))
	else
	begin
		fail_count++;
		$error("write and read strobes high together");
	end

	// data bus only driven for a hit port
	drive_on_hit: assert property (@(posedge zclk) disable iff (!rst_n) dataout |-> porthit)
	else
	begin
		fail_count++;
		$error("dataout high without porthit");
	end

endmodule

`default_nettype wire

/* tests/zports_tb.sv */
////////////////////////////////////////
// testbench of the Z80 port block, runs a table
// of bus cycles and checks the port rules
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zports_tb;

	localparam int K_CHK = 0; // check only
	localparam int K_WR  = 1; // bus write, then check
	localparam int K_RD  = 2; // bus read
	localparam int K_DOS = 3; // dos from data[0]
	localparam int TIMEOUT = 16;

	localparam int F_VCONF   = 0;
	localparam int F_VPAGE   = 1;
	localparam int F_XOFFS   = 2;
	localparam int F_YOFFS   = 3;
	localparam int F_TSCONF  = 4;
	localparam int F_PALSEL  = 5;
	localparam int F_BORDER  = 6;
	localparam int F_SYSCONF = 7;
	localparam int F_MEMCONF = 8;
	localparam int F_HINT    = 9;
	localparam int F_VINT    = 10;
	localparam int F_IM2     = 11;
	localparam int F_P1M     = 12;
	localparam int F_ROM     = 13;
	localparam int F_PEFF7   = 14;
	localparam int F_P7FFD   = 15;
	localparam int F_1M_ON   = 16;
	localparam int F_RAM0    = 17;
	localparam int F_RAMP    = 18; // four windows

	typedef struct packed {
		logic [2:0]  test;
		logic [1:0]  kind;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [4:0]  field;
		logic [15:0] expected; // read: {hit, dout}
	} entry_t;

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [7:0]  mus_in;

	wire zport_pkg::video_cfg_t  video;
	wire zport_pkg::sys_cfg_t    sys;
	wire [7:0]                   border;
	wire zport_pkg::page_state_t page;
	wire [7:0]                   dout;
	wire                         porthit;
	wire                         dataout;

	entry_t steps[$];
	int     checks;
	int     errors;
	int     t_checks;
	int     t_errors;

	// expected paging state
	logic [7:0] m_p7ffd;
	logic [7:0] m_eff7;
	logic [7:0] m_vpage;
	logic [5:0] m_p1m;
	logic       m_rom;
	logic       m_lock;

	zports_top dut_i (.zclk(zclk), .rst_n(rst_n), .a(a), .din(din), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .dos(dos), .keys_in(keys_in), .tape_read(tape_read),
		.mus_in(mus_in), .video(video), .sys(sys), .border(border), .page(page),
		.dout(dout), .porthit(porthit), .dataout(dataout));

	bind zport_bus_sync zports_checker strobe_chk (.zclk(zclk), .rst_n(rst_n),
		.wr(io.wr), .rd(io.rd), .porthit(1'b1), .dataout(1'b0));
	bind zports_top zports_checker hit_chk (.zclk(zclk), .rst_n(rst_n),
		.wr(1'b0), .rd(1'b0), .porthit(porthit), .dataout(dataout));

	always #10 zclk = ~zclk;

	////////////////////////////////////////
	// table building
	task automatic add(input int test, input int kind, input logic [15:0] addr,
		input logic [7:0] data, input int field, input logic [15:0] expected);
		entry_t e;
		e.test = 3'(test);
		e.kind = 2'(kind);
		e.addr = addr;
		e.data = data;
		e.field = 5'(field);
		e.expected = expected;
		steps.push_back(e);
	endtask

	task automatic xt_write(input int test, input logic [7:0] idx, input int field,
		input logic [7:0] mask);
		logic [7:0] d;
		d = 8'($urandom);
		add(test, K_WR, {idx, zport_pkg::PORT_XT}, d, field, {8'h00, d & mask});
	endtask

	// 9-bit register written as two halves
	task automatic wide_write(input logic [7:0] lo_idx, input logic [7:0] hi_idx,
		input int field);
		logic [7:0] d;
		logic [8:0] m;
		m = 9'd0;
		d = 8'($urandom);
		m[7:0] = d;
		add(2, K_WR, {lo_idx, zport_pkg::PORT_XT}, d, field, {7'd0, m});
		d = 8'($urandom) | 8'h01;
		m[8] = d[0];
		add(2, K_WR, {hi_idx, zport_pkg::PORT_XT}, d, field, {7'd0, m});
	endtask

	task automatic fd_write(input logic [7:0] d);
		if (!m_lock)
		begin
			m_lock = m_p7ffd[5] & m_eff7[2];
			m_p7ffd = d;
			m_p1m = {m_eff7[2] ? 3'b000 : {d[5], d[7:6]}, d[2:0]};
			m_rom = d[4];
			m_vpage = {6'b000001, d[3], 1'b1};
		end
		add(4, K_WR, 16'h7FFD, d, F_P7FFD, {8'h00, m_p7ffd});
		add(4, K_CHK, 0, 0, F_P1M, {10'd0, m_p1m});
		add(4, K_CHK, 0, 0, F_ROM, {15'd0, m_rom});
		add(4, K_CHK, 0, 0, F_VPAGE, {8'h00, m_vpage});
	endtask

	task automatic read_entry(input int test, input logic [15:0] addr,
		input logic [7:0] value, input logic hit);
		add(test, K_RD, addr, 8'h00, 0, {7'd0, hit, value});
	endtask

	task automatic build_steps();
		logic [7:0] d;
		logic [7:0] stat;
		add(1, K_CHK, 0, 0, F_HINT, 16'd2);
		add(1, K_CHK, 0, 0, F_IM2, 16'hFF);
		add(1, K_CHK, 0, 0, F_PALSEL, 16'h0F);
		add(1, K_CHK, 0, 0, F_VPAGE, 16'h05);
		add(1, K_CHK, 0, 0, F_RAMP, 16'h00);
		add(1, K_CHK, 0, 0, F_RAMP + 1, 16'h05);
		add(1, K_CHK, 0, 0, F_RAMP + 2, 16'h02);
		add(1, K_CHK, 0, 0, F_RAMP + 3, 16'h00);
		add(1, K_CHK, 0, 0, F_SYSCONF, 16'h00);
		add(1, K_CHK, 0, 0, F_MEMCONF, 16'h00);
		add(1, K_CHK, 0, 0, F_VINT, 16'h00);
		add(1, K_CHK, 0, 0, F_1M_ON, 16'h01); // EFF7 clear, 1 MB open
		add(1, K_CHK, 0, 0, F_RAM0, 16'h00);

		xt_write(2, zport_pkg::XT_VCONF, F_VCONF, 8'hFF);
		wide_write(zport_pkg::XT_XOFFSL, zport_pkg::XT_XOFFSH, F_XOFFS);
		wide_write(zport_pkg::XT_YOFFSL, zport_pkg::XT_YOFFSH, F_YOFFS);
		xt_write(2, zport_pkg::XT_TSCONF, F_TSCONF, 8'hFF);
		xt_write(2, zport_pkg::XT_PALSEL, F_PALSEL, 8'h0F); // 4-bit select
		xt_write(2, zport_pkg::XT_SYSCONF, F_SYSCONF, 8'hFF);
		xt_write(2, zport_pkg::XT_MEMCONF, F_MEMCONF, 8'hFF);
		xt_write(2, zport_pkg::XT_HSINT, F_HINT, 8'hFF);
		wide_write(zport_pkg::XT_VSINTL, zport_pkg::XT_VSINTH, F_VINT);
		xt_write(2, zport_pkg::XT_IM2VECT, F_IM2, 8'hFF);
		xt_write(2, zport_pkg::XT_VPAGE, F_VPAGE, 8'hFF);
		for (int i = 0; i < 4; i++)
			xt_write(2, zport_pkg::XT_RAMPAGE + 8'(i), F_RAMP + i, 8'hFF);

		// border, colour bits only from #FE
		d = 8'($urandom);
		add(3, K_WR, {8'h00, zport_pkg::PORT_FE}, d, F_BORDER, {8'h00, 5'b11110, d[2:0]});
		xt_write(3, zport_pkg::XT_BORDER, F_BORDER, 8'hFF);

		fd_write((8'($urandom) & 8'hDF) | 8'hC0); // high page bits visible
		d = 8'($urandom) | 8'h0C; // block1m and ram0_0 on
		m_eff7 = d;
		add(4, K_WR, 16'hEFF7, d, F_PEFF7, {8'h00, d & 8'hB1});
		add(4, K_CHK, 0, 0, F_1M_ON, {15'd0, ~d[2]});
		add(4, K_CHK, 0, 0, F_RAM0, {15'd0, d[3]});
		fd_write(8'($urandom) | 8'hE0); // upper bits masked, bit 5 arms lock
		fd_write(8'($urandom)); // accepted, locks
		fd_write(~m_p7ffd); // ignored

		stat = {1'b1, tape_read, 1'b0, keys_in};
		read_entry(5, 16'h00FE, stat, 1'b1);
		read_entry(5, {8'($urandom), 8'hF6}, stat, 1'b1);
		read_entry(5, 16'hFADF, mus_in, 1'b1);
		read_entry(5, 16'h0ABE, m_p7ffd, 1'b1);
		read_entry(5, 16'h0BBE, m_eff7 & 8'hB1, 1'b1);
		read_entry(5, 16'h0CBE, 8'hFF, 1'b1);
		read_entry(5, 16'h1234, 8'hFF, 1'b0);

		read_entry(6, 16'h7FFD, 8'hFF, 1'b1);
		read_entry(6, 16'h00AF, 8'hFF, 1'b1);
		read_entry(6, 16'hEFF7, 8'hFF, 1'b1);
		add(6, K_DOS, 0, 8'h01, 0, 0); // shadow on
		read_entry(6, 16'hEFF7, 8'hFF, 1'b0);
		read_entry(6, 16'h00FE, stat, 1'b1);
		add(6, K_DOS, 0, 8'h00, 0, 0);
		read_entry(6, 16'h0055, 8'hFF, 1'b0);
	endtask

	////////////////////////////////////////
	// bus cycles and checks
	function automatic logic [15:0] field_value(input int f);
		if (f >= F_RAMP)
			return {8'h00, sys.rampage[f - F_RAMP]};
		case (f)
			F_VCONF:   return {8'h00, video.vconf};
			F_VPAGE:   return {8'h00, video.vpage};
			F_XOFFS:   return {7'd0, video.x_offs};
			F_YOFFS:   return {7'd0, video.y_offs};
			F_TSCONF:  return {8'h00, video.tsconf};
			F_PALSEL:  return {12'h000, video.palsel};
			F_BORDER:  return {8'h00, border};
			F_SYSCONF: return {8'h00, sys.sysconf};
			F_MEMCONF: return {8'h00, sys.memconf};
			F_HINT:    return {8'h00, sys.hint_beg};
			F_VINT:    return {7'd0, sys.vint_beg};
			F_IM2:     return {8'h00, sys.im2vect};
			F_P1M:     return {10'd0, page.pent1m_page};
			F_ROM:     return {15'd0, page.pent1m_rom};
			F_PEFF7:   return {8'h00, page.peff7};
			F_P7FFD:   return {8'h00, page.p7ffd};
			F_1M_ON:   return {15'd0, page.pent1m_1m_on};
			F_RAM0:    return {15'd0, page.pent1m_ram0_0};
			default:   return 16'hxxxx;
		endcase
	endfunction

	task automatic check(input string what, input logic [15:0] got,
		input logic [15:0] expected);
		checks++;
		t_checks++;
		if (got !== expected)
		begin
			errors++;
			t_errors++;
			$display("FAIL %0t ns: %s, got %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic idle(input int cycles);
		for (int i = 0; i < cycles; i++)
			@(negedge zclk);
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		int n;
		a = addr;
		din = data;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		n = 0;
		do
		begin
			@(negedge zclk);
			n++;
		end
		while (!dut_i.u_bus_sync.io.wr && n < TIMEOUT);
		if (!dut_i.u_bus_sync.io.wr)
			abort_run($sformatf("timeout, no write strobe for port %h", addr));
		else
		begin
			while (n < 3) // bus held 3 cycles
			begin
				@(negedge zclk);
				n++;
			end
			iorq_n = 1'b1;
			wr_n = 1'b1;
			idle(2);
		end
	endtask

	task automatic bus_read(input entry_t e);
		int n;
		a = e.addr;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		n = 0;
		do
		begin
			@(negedge zclk);
			n++;
		end
		while (!dut_i.u_bus_sync.io.rd && n < TIMEOUT);
		if (!dut_i.u_bus_sync.io.rd)
			abort_run($sformatf("timeout, no read strobe for port %h", e.addr));
		else
		begin
			check($sformatf("dout of port %h", e.addr), {8'h00, dout}, {8'h00, e.expected[7:0]});
			check($sformatf("porthit of port %h", e.addr), porthit, e.expected[8]);
			check($sformatf("dataout of port %h", e.addr), dataout, e.expected[8]);
			iorq_n = 1'b1;
			rd_n = 1'b1;
			idle(1);
			check($sformatf("dataout after read of %h", e.addr), dataout, 1'b0);
			check($sformatf("idle porthit of %h", e.addr), porthit, e.expected[8]);
			idle(1);
		end
	endtask

	task automatic finish_test(input int num);
		$display("test %0d done: %0d checks, %0d errors", num, t_checks, t_errors);
		t_checks = 0;
		t_errors = 0;
	endtask

	initial
	begin
		entry_t e;
		int     cur;
		int     asserts;
		zclk = 1'b0;
		rst_n = 1'b0;
		a = 16'h0000;
		din = 8'h00;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		dos = 1'b0;
		void'($urandom(32'h3a8ba24a));
		keys_in = 5'($urandom);
		tape_read = 1'($urandom);
		mus_in = 8'($urandom);
		checks = 0;
		errors = 0;
		t_checks = 0;
		t_errors = 0;
		m_p7ffd = 8'h00;
		m_eff7 = 8'h00;
		m_vpage = 8'h05;
		m_p1m = 6'd0;
		m_rom = 1'b0;
		m_lock = 1'b0;
		build_steps();

		idle(16); // reset held
		rst_n = 1'b1;
		idle(1);
		cur = 1;
		foreach (steps[i])
		begin
			e = steps[i];
			if (e.test != cur)
			begin
				finish_test(cur);
				cur = e.test;
			end
			case (e.kind)
				K_WR:
				begin
					bus_write(e.addr, e.data);
					check($sformatf("step %0d field %0d", i, e.field), field_value(e.field),
						e.expected);
				end
				K_CHK: check($sformatf("step %0d field %0d", i, e.field),
					field_value(e.field), e.expected);
				K_RD: bus_read(e);
				default:
				begin
					dos = e.data[0];
					idle(1);
				end
			endcase
		end
		finish_test(cur);

		asserts = dut_i.u_bus_sync.strobe_chk.fail_count + dut_i.hit_chk.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asserts);
		if (errors == 0 && asserts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire
